//--- hw/vpu_pkg.sv
package vpu_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int ELEM_W = 16;
    localparam int REG_AW = 3;

    // --------------------
    // instruction format
    // --------------------
    typedef enum logic [3:0] {
        OP_FADD  = 4'd0,
        OP_FADD3 = 4'd1,
        OP_FSUB  = 4'd2,
        OP_FMAX2 = 4'd3,
        OP_FMAX3 = 4'd4,
        OP_FAVG2 = 4'd5,
        OP_FAVG3 = 4'd6,
        OP_FSUM  = 4'd7,
        OP_FMAX  = 4'd8
    } vpu_opcode_e;

    typedef struct packed {
        vpu_opcode_e       opcode;
        logic [REG_AW-1:0] src0;
        logic [REG_AW-1:0] src1;
        logic [REG_AW-1:0] src2;
        logic [REG_AW-1:0] dst0;
    } vpu_instr_t;

    // --------------------
    // decoded control
    // --------------------
    // one bit per kept function, all zero for an unknown opcode
    typedef struct packed {
        logic add2;
        logic add3;
        logic sub;
        logic max2;
        logic max3;
        logic avg2;
        logic avg3;
        logic sum;
        logic max;
    } vpu_fn_sel_t;

    typedef enum logic {
        EXEC = 1'b0,
        RED  = 1'b1
    } vpu_op_type_e;

    typedef struct packed {
        logic [2:0]        rvalid;
        vpu_fn_sel_t       fn;
        vpu_op_type_e      op_type;
        logic [REG_AW-1:0] raddr0;
        logic [REG_AW-1:0] raddr1;
        logic [REG_AW-1:0] raddr2;
        logic [REG_AW-1:0] waddr;
    } vpu_decoded_t;

    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,
        S_READ  = 2'd1,
        S_EXEC  = 2'd2,
        S_WRITE = 2'd3
    } vpu_state_e;

endpackage

//--- hw/vpu_decoder.sv
`timescale 1ns/1ps

module vpu_decoder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  vpu_pkg::vpu_instr_t   req_instr,
    output logic                  req_ready,
    output logic                  ctrl_valid,
    input  logic                  ctrl_ready,
    output vpu_pkg::vpu_decoded_t decoded
);
    import vpu_pkg::*;

    vpu_instr_t instr_q;

    // handshake goes straight through to the controller
    assign req_ready  = ctrl_ready;
    assign ctrl_valid = req_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instr_q <= '0;
        end else if (req_valid && ctrl_ready) begin
            instr_q <= req_instr;
        end
    end

    always_comb begin
        decoded = '0;

        // read-port mask
        case (instr_q.opcode)
            OP_FSUM, OP_FMAX:             decoded.rvalid = 3'b001;
            OP_FADD3, OP_FMAX3, OP_FAVG3: decoded.rvalid = 3'b111;
            default:                      decoded.rvalid = 3'b011;
        endcase

        // function select and op type
        decoded.op_type = EXEC;
        case (instr_q.opcode)
            OP_FADD:  decoded.fn.add2 = 1'b1;
            OP_FADD3: decoded.fn.add3 = 1'b1;
            OP_FSUB:  decoded.fn.sub  = 1'b1;
            OP_FMAX2: decoded.fn.max2 = 1'b1;
            OP_FMAX3: decoded.fn.max3 = 1'b1;
            OP_FAVG2: decoded.fn.avg2 = 1'b1;
            OP_FAVG3: decoded.fn.avg3 = 1'b1;
            OP_FSUM: begin
                decoded.fn.sum  = 1'b1;
                decoded.op_type = RED;
            end
            OP_FMAX: begin
                decoded.fn.max  = 1'b1;
                decoded.op_type = RED;
            end
            default:  decoded.fn = '0;
        endcase

        decoded.raddr0 = instr_q.src0;
        decoded.raddr1 = instr_q.src1;
        decoded.raddr2 = instr_q.src2;
        decoded.waddr  = instr_q.dst0;
    end

    // the exec unit relies on at most one function being selected
    a_fn_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(decoded.fn));

endmodule

//--- hw/vpu_ctrl_fsm.sv
`timescale 1ns/1ps

module vpu_ctrl_fsm #(
    parameter int LANES = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ctrl_valid,
    output logic                  ctrl_ready,
    input  vpu_pkg::vpu_op_type_e op_type,
    input  logic                  last_lane,
    output logic                  rd_en,
    output logic                  exec_start,
    output logic                  wr_en,
    output logic                  done
);
    import vpu_pkg::*;

    localparam int CW = $clog2(LANES) + 1;

    vpu_state_e    state;
    vpu_state_e    state_n;
    logic [CW-1:0] exec_cnt;

    always_comb begin
        state_n = state;
        case (state)
            S_IDLE:  if (ctrl_valid && ctrl_ready) state_n = S_READ;
            S_READ:  state_n = S_EXEC;
            // reductions stay until the lane counter reaches the end
            S_EXEC:  if (op_type == EXEC || last_lane) state_n = S_WRITE;
            S_WRITE: state_n = S_IDLE;
            default: state_n = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            ctrl_ready <= 1'b1;
            exec_start <= 1'b0;
            done       <= 1'b0;
        end else begin
            state      <= state_n;
            ctrl_ready <= (state_n == S_IDLE);
            exec_start <= (state_n == S_EXEC) && (state != S_EXEC);
            done       <= (state_n == S_WRITE);
        end
    end

    // cycles spent in exec, only watched by the check below
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exec_cnt <= '0;
        end else if (state == S_EXEC) begin
            exec_cnt <= exec_cnt + 1'b1;
        end else begin
            exec_cnt <= '0;
        end
    end

    assign rd_en = (state == S_READ);
    assign wr_en = (state == S_WRITE);

    a_done_with_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en == done);

    a_ready_idle_only: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_ready |-> state == S_IDLE);

    // lane counter must release a reduction within LANES cycles
    a_exec_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        state == S_EXEC |-> exec_cnt < CW'(LANES));

endmodule

//--- hw/vpu_lane_counter.sv
`timescale 1ns/1ps

module vpu_lane_counter #(
    parameter int LANES = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       exec_start,
    output logic [$clog2(LANES)-1:0]   lane_idx,
    output logic                       last_lane
);
    localparam int              LW   = $clog2(LANES);
    localparam logic [LW-1:0]   LAST = LW'(LANES - 1);

    logic [LW-1:0] cnt;

    // lane 0 is the start cycle itself, so the count resumes at 1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (exec_start) begin
            cnt <= LW'(1);
        end else if (cnt != LAST) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign lane_idx  = exec_start ? '0 : cnt;
    assign last_lane = (lane_idx == LAST);

    a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        cnt <= LAST);

endmodule

//--- hw/vpu_vreg_file.sv
`timescale 1ns/1ps

module vpu_vreg_file #(
    parameter int LANES = 4
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     rd_en,
    input  logic [2:0]                               rvalid,
    input  logic [vpu_pkg::REG_AW-1:0]               raddr0,
    input  logic [vpu_pkg::REG_AW-1:0]               raddr1,
    input  logic [vpu_pkg::REG_AW-1:0]               raddr2,
    input  logic                                     wr_en,
    input  logic [vpu_pkg::REG_AW-1:0]               waddr,
    input  logic [LANES-1:0][vpu_pkg::ELEM_W-1:0]    wdata,
    input  logic                                     host_wr_en,
    input  logic [vpu_pkg::REG_AW-1:0]               host_waddr,
    input  logic [LANES-1:0][vpu_pkg::ELEM_W-1:0]    host_wdata,
    input  logic [vpu_pkg::REG_AW-1:0]               host_raddr,
    output logic [LANES-1:0][vpu_pkg::ELEM_W-1:0]    op0,
    output logic [LANES-1:0][vpu_pkg::ELEM_W-1:0]    op1,
    output logic [LANES-1:0][vpu_pkg::ELEM_W-1:0]    op2,
    output logic [LANES-1:0][vpu_pkg::ELEM_W-1:0]    host_rdata
);
    import vpu_pkg::*;

    localparam int NREG = 2 ** REG_AW;

    typedef logic [LANES-1:0][ELEM_W-1:0] vec_t;

    vec_t regs [NREG];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NREG; i++) begin
                regs[i] <= '0;
            end
            op0 <= '0;
            op1 <= '0;
            op2 <= '0;
        end else begin
            // write-back has priority, host writes only while idle
            if (wr_en) begin
                regs[waddr] <= wdata;
            end else if (host_wr_en) begin
                regs[host_waddr] <= host_wdata;
            end
            // unused ports read as zero
            if (rd_en) begin
                op0 <= rvalid[0] ? regs[raddr0] : '0;
                op1 <= rvalid[1] ? regs[raddr1] : '0;
                op2 <= rvalid[2] ? regs[raddr2] : '0;
            end
        end
    end

    assign host_rdata = regs[host_raddr];

    a_no_write_clash: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_en && host_wr_en));

endmodule

//--- hw/vpu_exec_unit.sv
`timescale 1ns/1ps

module vpu_exec_unit #(
    parameter int LANES = 4
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     exec_start,
    input  vpu_pkg::vpu_fn_sel_t                     fn,
    input  vpu_pkg::vpu_op_type_e                    op_type,
    input  logic [$clog2(LANES)-1:0]                 lane_idx,
    input  logic [LANES-1:0][vpu_pkg::ELEM_W-1:0]    op0,
    input  logic [LANES-1:0][vpu_pkg::ELEM_W-1:0]    op1,
    input  logic [LANES-1:0][vpu_pkg::ELEM_W-1:0]    op2,
    output logic [LANES-1:0][vpu_pkg::ELEM_W-1:0]    result
);
    import vpu_pkg::*;

    localparam int                       LW   = $clog2(LANES);
    localparam logic [LW-1:0]            LAST = LW'(LANES - 1);

    typedef logic [LANES-1:0][ELEM_W-1:0] vec_t;

    vec_t                     ew;
    logic                     red_active;
    logic signed [ELEM_W-1:0] acc;
    logic signed [ELEM_W-1:0] lane_v;
    logic signed [ELEM_W-1:0] fold_v;

    // --------------------
    // element-wise lanes
    // --------------------
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        logic signed [ELEM_W-1:0] a, b, c, m2, res;
        logic signed [ELEM_W:0]   s2w;
        logic signed [ELEM_W+1:0] s3w, q3;

        assign a   = op0[i];
        assign b   = op1[i];
        assign c   = op2[i];
        assign m2  = (a > b) ? a : b;
        // widened sums so the averages see no overflow
        assign s2w = a + b;
        assign s3w = a + b + c;
        // signed divide truncates toward zero
        assign q3  = s3w / 3;

        always_comb begin
            res = '0;
            if (fn.add2)      res = a + b;
            else if (fn.add3) res = a + b + c;
            else if (fn.sub)  res = a - b;
            else if (fn.max2) res = m2;
            else if (fn.max3) res = (m2 > c) ? m2 : c;
            else if (fn.avg2) res = s2w[ELEM_W:1];
            else if (fn.avg3) res = q3[ELEM_W-1:0];
        end

        assign ew[i] = res;
    end

    // --------------------
    // reduction
    // --------------------
    // lane 0 of the result register is the accumulator
    assign acc    = result[0];
    assign lane_v = op0[lane_idx];

    always_comb begin
        fold_v = acc;
        if (fn.sum)      fold_v = acc + lane_v;
        else if (fn.max) fold_v = (lane_v > acc) ? lane_v : acc;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result     <= '0;
            red_active <= 1'b0;
        end else if (exec_start) begin
            if (op_type == RED) begin
                result     <= vec_t'(op0[0]);
                red_active <= 1'b1;
            end else begin
                result <= ew;
            end
        end else if (red_active) begin
            result[0] <= fold_v;
            if (lane_idx == LAST) red_active <= 1'b0;
        end
    end

endmodule

//--- hw/vpu_top.sv
`timescale 1ns/1ps

module vpu_top #(
    parameter int LANES = 4
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     req_valid,
    input  vpu_pkg::vpu_instr_t                      req_instr,
    output logic                                     req_ready,
    input  logic                                     host_wr_en,
    input  logic [vpu_pkg::REG_AW-1:0]               host_waddr,
    input  logic [LANES-1:0][vpu_pkg::ELEM_W-1:0]    host_wdata,
    input  logic [vpu_pkg::REG_AW-1:0]               host_raddr,
    output logic [LANES-1:0][vpu_pkg::ELEM_W-1:0]    host_rdata,
    output logic                                     done
);
    import vpu_pkg::*;

    logic                            ctrl_valid;
    logic                            ctrl_ready;
    vpu_decoded_t                    decoded;
    logic                            rd_en;
    logic                            exec_start;
    logic                            wr_en;
    logic                            last_lane;
    logic [$clog2(LANES)-1:0]        lane_idx;
    logic [LANES-1:0][ELEM_W-1:0]    op0;
    logic [LANES-1:0][ELEM_W-1:0]    op1;
    logic [LANES-1:0][ELEM_W-1:0]    op2;
    logic [LANES-1:0][ELEM_W-1:0]    result;

    vpu_decoder u_dec (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_instr  (req_instr),
        .req_ready  (req_ready),
        .ctrl_valid (ctrl_valid),
        .ctrl_ready (ctrl_ready),
        .decoded    (decoded)
    );

    vpu_ctrl_fsm #(.LANES(LANES)) u_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl_valid (ctrl_valid),
        .ctrl_ready (ctrl_ready),
        .op_type    (decoded.op_type),
        .last_lane  (last_lane),
        .rd_en      (rd_en),
        .exec_start (exec_start),
        .wr_en      (wr_en),
        .done       (done)
    );

    vpu_lane_counter #(.LANES(LANES)) u_lane (
        .clk        (clk),
        .rst_n      (rst_n),
        .exec_start (exec_start),
        .lane_idx   (lane_idx),
        .last_lane  (last_lane)
    );

    vpu_vreg_file #(.LANES(LANES)) u_rf (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_en      (rd_en),
        .rvalid     (decoded.rvalid),
        .raddr0     (decoded.raddr0),
        .raddr1     (decoded.raddr1),
        .raddr2     (decoded.raddr2),
        .wr_en      (wr_en),
        .waddr      (decoded.waddr),
        .wdata      (result),
        .host_wr_en (host_wr_en),
        .host_waddr (host_waddr),
        .host_wdata (host_wdata),
        .host_raddr (host_raddr),
        .op0        (op0),
        .op1        (op1),
        .op2        (op2),
        .host_rdata (host_rdata)
    );

    vpu_exec_unit #(.LANES(LANES)) u_exe (
        .clk        (clk),
        .rst_n      (rst_n),
        .exec_start (exec_start),
        .fn         (decoded.fn),
        .op_type    (decoded.op_type),
        .lane_idx   (lane_idx),
        .op0        (op0),
        .op1        (op1),
        .op2        (op2),
        .result     (result)
    );

endmodule

//--- sim/vpu_checker.sv
`timescale 1ns/1ps

module vpu_checker #(
    parameter int LANES = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  req_valid,
    input  vpu_pkg::vpu_instr_t                   req_instr,
    input  logic                                  req_ready,
    input  logic                                  done,
    input  logic                                  host_wr_en,
    input  logic [vpu_pkg::REG_AW-1:0]            host_waddr,
    input  logic [LANES-1:0][vpu_pkg::ELEM_W-1:0] host_wdata,
    input  logic [vpu_pkg::REG_AW-1:0]            host_raddr,
    input  logic [LANES-1:0][vpu_pkg::ELEM_W-1:0] host_rdata,
    input  logic                                  readback,
    input  int                                    exp_lat,
    output int                                    value_errs,
    output int                                    proto_errs,
    output int                                    reads
);
    import vpu_pkg::*;

    localparam int NREG = 2 ** REG_AW;

    typedef logic [LANES-1:0][ELEM_W-1:0] vec_t;

    vec_t              model [NREG];
    vec_t              pend_data;
    logic [REG_AW-1:0] pend_dst;
    logic              busy;
    int                cyc;
    int                lat_q;

    // reference result from the model, lane rules of the VPU
    function automatic vec_t expect_result(vpu_instr_t ins);
        vec_t res;
        int   a, b, c, acc;
        res = '0;
        if (ins.opcode == OP_FSUM || ins.opcode == OP_FMAX) begin
            // fold src0 from lane 0 upward, scalar lands in lane 0
            acc = $signed(model[ins.src0][0]);
            for (int i = 1; i < LANES; i++) begin
                a = $signed(model[ins.src0][i]);
                if (ins.opcode == OP_FSUM) begin
                    acc = acc + a;
                end else if (a > acc) begin
                    acc = a;
                end
            end
            res[0] = acc[ELEM_W-1:0];
            return res;
        end
        for (int i = 0; i < LANES; i++) begin
            a = $signed(model[ins.src0][i]);
            b = $signed(model[ins.src1][i]);
            c = $signed(model[ins.src2][i]);
            case (ins.opcode)
                OP_FADD:  acc = a + b;
                OP_FADD3: acc = a + b + c;
                OP_FSUB:  acc = a - b;
                OP_FMAX2: acc = (a > b) ? a : b;
                OP_FMAX3: acc = (a > b) ? ((a > c) ? a : c) : ((b > c) ? b : c);
                OP_FAVG2: acc = (a + b) >>> 1;
                // int division rounds toward zero
                OP_FAVG3: acc = (a + b + c) / 3;
                default:  acc = 0;
            endcase
            res[i] = acc[ELEM_W-1:0];
        end
        return res;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < NREG; r++) begin
                model[r] = '0;
            end
            busy       = 1'b0;
            cyc        = 0;
            value_errs = 0;
            proto_errs = 0;
            reads      = 0;
        end else begin
            // host_rdata still shows the contents before this edge
            if (readback) begin
                reads++;
                if (host_rdata !== model[host_raddr]) begin
                    value_errs++;
                    $display("[FAIL] %0d ns: v%0d reads %h, expected %h",
                             $time, host_raddr, host_rdata, model[host_raddr]);
                end
            end

            if (busy) begin
                cyc++;
                if (req_ready) begin
                    proto_errs++;
                    $display("error at %0d ns: req_ready high while an instruction is busy",
                             $time);
                end
                if (done) begin
                    if (cyc != lat_q) begin
                        proto_errs++;
                        $display("error at %0d ns: done came %0d cycles after transfer, not %0d",
                                 $time, cyc, lat_q);
                    end
                    model[pend_dst] = pend_data;
                    busy            = 1'b0;
                end
            end else begin
                if (done) begin
                    proto_errs++;
                    $display("error at %0d ns: done pulsed with no instruction in flight", $time);
                end
                if (!req_ready) begin
                    proto_errs++;
                    $display("error at %0d ns: req_ready low while the VPU is idle", $time);
                end
            end

            if (host_wr_en) begin
                model[host_waddr] = host_wdata;
            end

            if (req_valid && req_ready) begin
                pend_data = expect_result(req_instr);
                pend_dst  = req_instr.dst0;
                lat_q     = exp_lat;
                busy      = 1'b1;
                cyc       = 0;
            end
        end
    end

endmodule

//--- sim/tb_vpu.sv
`timescale 1ns/1ps

module tb_vpu;
    import vpu_pkg::*;

    localparam int          LANES     = 4;
    localparam int          NREG      = 2 ** REG_AW;
    localparam int          N_TESTS   = 15;
    localparam int          N_BACKPR  = 2;
    localparam int          N_PRELOAD = NREG;
    localparam int          EXP_READS = NREG + N_TESTS + N_BACKPR;
    localparam int unsigned SEED      = 32'hc12264e3;
    localparam int          WATCH_CYCLES = (N_TESTS + N_BACKPR) * (LANES + 8) + N_PRELOAD + 50;

    typedef logic [LANES-1:0][ELEM_W-1:0] vec_t;

    // one table row, instruction and expected cycles from transfer to done
    typedef struct packed {
        vpu_instr_t instr;
        logic [7:0] lat;
    } test_t;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              req_valid;
    vpu_instr_t        req_instr;
    logic              req_ready;
    logic              host_wr_en;
    logic [REG_AW-1:0] host_waddr;
    vec_t              host_wdata;
    logic [REG_AW-1:0] host_raddr;
    vec_t              host_rdata;
    logic              done;
    logic              readback;
    int                exp_lat;
    int                value_errs;
    int                proto_errs;
    int                reads;
    int unsigned       seed_val;
    test_t             tests [N_TESTS];
    test_t             bp_tests [N_BACKPR];

    always #5 clk = ~clk;

    vpu_top #(.LANES(LANES)) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_instr  (req_instr),
        .req_ready  (req_ready),
        .host_wr_en (host_wr_en),
        .host_waddr (host_waddr),
        .host_wdata (host_wdata),
        .host_raddr (host_raddr),
        .host_rdata (host_rdata),
        .done       (done)
    );

    vpu_checker #(.LANES(LANES)) u_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_instr  (req_instr),
        .req_ready  (req_ready),
        .done       (done),
        .host_wr_en (host_wr_en),
        .host_waddr (host_waddr),
        .host_wdata (host_wdata),
        .host_raddr (host_raddr),
        .host_rdata (host_rdata),
        .readback   (readback),
        .exp_lat    (exp_lat),
        .value_errs (value_errs),
        .proto_errs (proto_errs),
        .reads      (reads)
    );

    // --------------------
    // helpers
    // --------------------
    function automatic test_t row(vpu_opcode_e op, int s0, int s1, int s2, int d, int lat);
        test_t t;
        t.instr.opcode = op;
        t.instr.src0   = REG_AW'(s0);
        t.instr.src1   = REG_AW'(s1);
        t.instr.src2   = REG_AW'(s2);
        t.instr.dst0   = REG_AW'(d);
        t.lat          = 8'(lat);
        return t;
    endfunction

    function automatic vec_t rand_vec();
        vec_t v;
        for (int i = 0; i < LANES; i++) begin
            v[i] = ELEM_W'($urandom());
        end
        return v;
    endfunction

    // all tasks are entered on a falling edge and return on one
    task automatic host_write(input int r, input vec_t v);
        host_wr_en = 1'b1;
        host_waddr = REG_AW'(r);
        host_wdata = v;
        @(negedge clk);
        host_wr_en = 1'b0;
    endtask

    task automatic read_back(input int r);
        host_raddr = REG_AW'(r);
        readback   = 1'b1;
        @(negedge clk);
        readback   = 1'b0;
    endtask

    task automatic send_instr(input vpu_instr_t ins, input int lat);
        req_instr = ins;
        exp_lat   = lat;
        req_valid = 1'b1;
        // held while busy, transfer happens on the edge after ready is seen
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_done();
        while (!done) @(negedge clk);
        // write-back lands on the following edge
        @(negedge clk);
    endtask

    // --------------------
    // stimulus table
    // --------------------
    // v0..v4 random, v5 all max, v6 min and -1 alternating, v7 small negatives
    initial begin
        tests[0]  = row(OP_FADD,  5, 5, 0, 0, 3);
        tests[1]  = row(OP_FSUB,  6, 5, 0, 1, 3);
        tests[2]  = row(OP_FMAX2, 6, 7, 0, 2, 3);
        tests[3]  = row(OP_FAVG2, 6, 7, 0, 3, 3);
        tests[4]  = row(OP_FAVG2, 4, 3, 0, 4, 3);
        tests[5]  = row(OP_FADD3, 0, 1, 7, 0, 3);
        tests[6]  = row(OP_FMAX3, 4, 6, 7, 1, 3);
        tests[7]  = row(OP_FAVG3, 7, 6, 5, 2, 3);
        tests[8]  = row(OP_FAVG3, 7, 7, 3, 3, 3);
        tests[9]  = row(OP_FSUM,  5, 0, 0, 4, LANES + 2);
        tests[10] = row(OP_FMAX,  7, 0, 0, 0, LANES + 2);
        tests[11] = row(OP_FSUM,  6, 0, 0, 1, LANES + 2);
        tests[12] = row(OP_FMAX,  4, 0, 0, 2, LANES + 2);
        tests[13] = row(vpu_opcode_e'(4'd12), 0, 1, 2, 3, 3);
        tests[14] = row(OP_FSUB,  4, 0, 0, 4, 3);
        // second one is offered while the first is still busy
        bp_tests[0] = row(OP_FSUM, 0, 0, 0, 5, LANES + 2);
        bp_tests[1] = row(OP_FADD, 5, 1, 0, 6, 3);
    end

    // --------------------
    // main sequence
    // --------------------
    initial begin
        vec_t v_max;
        vec_t v_min;
        vec_t v_neg;
        seed_val   = $urandom(SEED);
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_instr  = '0;
        host_wr_en = 1'b0;
        host_waddr = '0;
        host_wdata = '0;
        host_raddr = '0;
        readback   = 1'b0;
        exp_lat    = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // registers must read zero out of reset
        for (int r = 0; r < NREG; r++) begin
            read_back(r);
        end

        for (int i = 0; i < LANES; i++) begin
            v_max[i] = 16'h7fff;
            v_min[i] = (i % 2 == 0) ? 16'h8000 : 16'hffff;
            v_neg[i] = ELEM_W'(-(i + 1));
        end
        for (int r = 0; r < 5; r++) begin
            host_write(r, rand_vec());
        end
        host_write(5, v_max);
        host_write(6, v_min);
        host_write(7, v_neg);

        foreach (tests[t]) begin
            send_instr(tests[t].instr, int'(tests[t].lat));
            wait_done();
            read_back(int'(tests[t].instr.dst0));
        end

        send_instr(bp_tests[0].instr, int'(bp_tests[0].lat));
        send_instr(bp_tests[1].instr, int'(bp_tests[1].lat));
        wait_done();
        read_back(5);
        read_back(6);

        @(negedge clk);
        $display("summary: %0d read-backs, %0d value errors, %0d protocol errors",
                 reads, value_errs, proto_errs);
        if (reads != EXP_READS) begin
            $display("error: %0d read-backs were compared instead of %0d", reads, EXP_READS);
        end
        if (value_errs == 0 && proto_errs == 0 && reads == EXP_READS) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("timeout: run still going after %0d cycles", WATCH_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- filelist.f
hw/vpu_pkg.sv
hw/vpu_decoder.sv
hw/vpu_ctrl_fsm.sv
hw/vpu_lane_counter.sv
hw/vpu_vreg_file.sv
hw/vpu_exec_unit.sv
hw/vpu_top.sv
sim/vpu_checker.sv
sim/tb_vpu.sv
